// ==== sources.f ====
design/uart_pkg.sv
design/sync_fifo.sv
design/uart_transmit.sv
design/uart_receive.sv
design/uart.sv
verification/tb_clock_gen.sv
verification/uart_tb.sv

// ==== verification/uart_tb.sv ====
/*
 * Serial port testbench
 * Random bytes through both serial paths, checked against a queue model
 */
`default_nettype none

module uart_tb;

	// Bit and frame timing
	localparam int BIT_CLKS = uart_pkg::CLKS_PER_SAMPLE * uart_pkg::SAMPLES_PER_BIT;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	// Worst frame with gap and reads, about 200 cycles
	localparam int FRAME_BUDGET = FRAME_CLKS + 40;
	// About 35 frames in all, plus margin
	localparam int TIMEOUT_CYCLES = 40 * FRAME_BUDGET * 5 / 2;

	logic clk;
	logic arst_n;
	logic [31:0] io_address;
	logic io_read_en;
	logic io_write_en;
	logic [31:0] io_write_data;
	logic [31:0] io_read_data;
	logic uart_tx;
	logic uart_rx;

	logic [31:0] lcg_state;
	int cycle_count = 0;

	// Model of FIFO contents, frame_error above the character
	logic [8:0] rx_model [$];
	logic overrun_model;
	// Characters decoded from uart_tx
	logic [7:0] tx_seen [$];

	tb_clock_gen clock_gen_inst
	(
		.clk(clk)
	);

	uart uart_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx)
	);

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
			$display("Regression failed");
			$fatal(1, "mismatch in %s", test_name);
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper bits, the low LCG bits repeat quickly
	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[23:16];
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Read data without a strobe, so no side effect
	task automatic peek_reg(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		io_address = addr;
		#2;
		data = io_read_data;
	endtask

	// Strobe held over exactly one rising edge
	task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		io_address = addr;
		io_read_en = 1'b1;
		#2;
		data = io_read_data;
		@(negedge clk);
		io_read_en = 1'b0;
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		io_address = addr;
		io_write_data = data;
		io_write_en = 1'b1;
		@(negedge clk);
		io_write_en = 1'b0;
	endtask

	// One 8N1 frame on uart_rx, line left high
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			uart_rx = frame[i];
			repeat (BIT_CLKS - 1) @(negedge clk);
		end
		@(negedge clk);
		uart_rx = 1'b1;
	endtask

	// Frame plus its expected effect, a full FIFO drops it
	task automatic send_modeled(input logic [7:0] data, input logic stop_bit);
		send_frame(data, stop_bit);
		if (rx_model.size() < uart_pkg::RX_FIFO_DEPTH)
			rx_model.push_back({!stop_bit, data});
		else
			overrun_model = 1'b1;
	endtask

	// Transmitter idle outside the transmit test
	function automatic logic [31:0] expected_status();
		uart_pkg::status_t s;
		s = '0;
		s.tx_ready = 1'b1;
		s.rx_available = rx_model.size() != 0;
		s.rx_overrun = overrun_model;
		return s;
	endfunction

	task automatic check_rx_read(input string test_name);
		logic [31:0] expected;
		logic [31:0] word;
		expected = '0;
		if (rx_model.size() != 0)
			expected = {23'h0, rx_model.pop_front()};
		read_reg(uart_pkg::RX_ADDR, word);
		check_value(test_name, expected, word);
	endtask

	// Strobed status read clears overrun at the edge
	task automatic check_status_read(input string test_name);
		logic [31:0] expected;
		logic [31:0] word;
		expected = expected_status();
		read_reg(uart_pkg::STATUS_ADDR, word);
		check_value(test_name, expected, word);
		overrun_model = 1'b0;
	endtask

	task automatic check_status_peek(input string test_name);
		logic [31:0] word;
		peek_reg(uart_pkg::STATUS_ADDR, word);
		check_value(test_name, expected_status(), word);
	endtask

	task automatic transmit_test();
		logic [7:0] tx_byte;
		logic [31:0] word;
		int low_cycles;
		for (int i = 0; i < 12; i++)
		begin
			tx_byte = random_byte();
			// Wait for tx_ready before writing
			do
				peek_reg(uart_pkg::STATUS_ADDR, word);
			while (!word[0]);
			write_reg(uart_pkg::TX_ADDR, {24'h0, tx_byte});
			// Falling edge just after the start edge counts as one
			low_cycles = 1;
			peek_reg(uart_pkg::STATUS_ADDR, word);
			while (!word[0])
			begin
				low_cycles++;
				if (low_cycles == 40)
				begin
					// Mid-frame write, must be ignored
					write_reg(uart_pkg::TX_ADDR, {24'h0, ~tx_byte});
					low_cycles += 2;
				end
				peek_reg(uart_pkg::STATUS_ADDR, word);
			end
			check_value("tx busy cycles", FRAME_CLKS, low_cycles);
			check_value("tx frame count", 1, tx_seen.size());
			check_value("tx data", {24'h0, tx_byte}, {24'h0, tx_seen.pop_front()});
		end
	endtask

	task automatic receive_test();
		logic [31:0] rnd;
		int reads;
		for (int i = 0; i < 12; i++)
		begin
			send_modeled(random_byte(), 1'b1);
			check_status_peek("rx available");
			rnd = lcg_next();
			// Zero to three reads between frames
			reads = int'(rnd[17:16]);
			for (int r = 0; r < reads; r++)
				check_rx_read("rx data");
			idle_cycles(int'(rnd[28:24]));
		end
		while (rx_model.size() != 0)
			check_rx_read("rx drain");
		check_status_peek("rx drained");
	endtask

	task automatic framing_test();
		send_modeled(random_byte(), 1'b0);
		// Receiver rejects the low tail of the stop bit as a start bit
		idle_cycles(2 * BIT_CLKS);
		check_rx_read("framing error");
		check_status_peek("framing no extra frame");
	endtask

	task automatic overrun_test();
		for (int i = 0; i < 10; i++)
		begin
			send_modeled(random_byte(), 1'b1);
			idle_cycles(4);
		end
		for (int i = 0; i < uart_pkg::RX_FIFO_DEPTH; i++)
			check_rx_read("overrun data");
		check_status_read("overrun set");
		check_status_read("overrun cleared");
		check_rx_read("empty rx read");
		check_status_peek("empty read status");
	endtask

	// Decodes each uart_tx frame at bit centers
	initial
	begin : tx_monitor
		logic [7:0] bits;
		wait (arst_n === 1'b1);
		forever
		begin
			@(negedge uart_tx);
			repeat (BIT_CLKS / 2) @(posedge clk);
			check_value("tx start bit", 32'h0, {31'h0, uart_tx});
			for (int b = 0; b < 8; b++)
			begin
				repeat (BIT_CLKS) @(posedge clk);
				bits[b] = uart_tx;
			end
			repeat (BIT_CLKS) @(posedge clk);
			check_value("tx stop bit", 32'h1, {31'h0, uart_tx});
			tx_seen.push_back(bits);
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the DUT never finished the tests", cycle_count);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [31:0] word;
		arst_n = 1'b0;
		io_address = '0;
		io_read_en = 1'b0;
		io_write_en = 1'b0;
		io_write_data = '0;
		uart_rx = 1'b1;
		lcg_state = 32'hc905_6bd0;
		overrun_model = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// Reset state
		peek_reg(uart_pkg::STATUS_ADDR, word);
		check_value("reset status", expected_status(), word);
		check_value("reset uart_tx", 32'h1, {31'h0, uart_tx});

		transmit_test();
		receive_test();
		framing_test();
		overrun_test();

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
/*
 * Testbench clock source, free running with a period of 10
 */
`default_nettype none

module tb_clock_gen
(
	output logic clk
);

	// Low first, rising edge at 5
	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== design/uart.sv ====
/*
 * Memory-mapped serial port
 * Status, receive and transmit registers over the transmitter, receiver and receive FIFO
 */
`default_nettype none

module uart
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic [31:0] io_address,
	input wire logic io_read_en,
	input wire logic io_write_en,
	input wire logic [31:0] io_write_data,
	output logic [31:0] io_read_data,
	output logic uart_tx,
	input wire logic uart_rx
);

	// Address decode
	logic status_sel;
	logic rx_sel;
	logic tx_sel;

	logic tx_ready;
	logic tx_start;

	uart_pkg::rx_entry_t rx_entry;
	logic rx_valid;

	uart_pkg::rx_entry_t fifo_head;
	logic fifo_enqueue;
	logic fifo_dequeue;
	logic fifo_full;
	logic fifo_empty;

	// Sticky until status is read
	logic rx_overrun;

	uart_pkg::io_word_u read_word;

	assign status_sel = io_address == uart_pkg::STATUS_ADDR;
	assign rx_sel = io_address == uart_pkg::RX_ADDR;
	assign tx_sel = io_address == uart_pkg::TX_ADDR;

	// Writes while a frame is in flight are dropped
	assign tx_start = io_write_en && tx_sel && tx_ready;

	// Pop only a real entry
	assign fifo_dequeue = io_read_en && rx_sel && !fifo_empty;
	// Full FIFO drops the character
	assign fifo_enqueue = rx_valid && !fifo_full;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rx_overrun <= 1'b0;
		else if (rx_valid && fifo_full)
			rx_overrun <= 1'b1;  // new loss wins over a same-cycle clear
		else if (io_read_en && status_sel)
			rx_overrun <= 1'b0;
	end

	// Read word valid in the same cycle as the address
	always_comb
	begin
		read_word = '0;
		case (1'b1)
			status_sel:
			begin
				read_word.status.reserved = '0;
				read_word.status.rx_overrun = rx_overrun;
				read_word.status.rx_available = !fifo_empty;
				read_word.status.tx_ready = tx_ready;
			end
			rx_sel:
			begin
				read_word.rx.reserved = '0;
				// Empty FIFO reads as zero
				read_word.rx.entry = fifo_empty ? '0 : fifo_head;
			end
			default: read_word = '0;
		endcase
		io_read_data = read_word;
	end

	uart_transmit uart_transmit_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.tx_start(tx_start),
		.tx_char(io_write_data[7:0]),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx)
	);

	uart_receive uart_receive_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.uart_rx(uart_rx),
		.rx_entry(rx_entry),
		.rx_valid(rx_valid)
	);

	sync_fifo rx_fifo_inst
	(
		.clk(clk),
		.arst_n(arst_n),
		.enqueue(fifo_enqueue),
		.wr_entry(rx_entry),
		.dequeue(fifo_dequeue),
		.rd_entry(fifo_head),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	// FIFO flags follow each gated push and pop without wrapping
	push_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
		fifo_enqueue |=> !fifo_empty)
		else $error("uart: FIFO empty after enqueue");

	pop_not_full: assert property (@(posedge clk) disable iff (!arst_n)
		fifo_dequeue && !fifo_enqueue |=> !fifo_full)
		else $error("uart: FIFO full after dequeue");

endmodule

`default_nettype wire

// ==== design/uart_receive.sv ====
/*
 * Serial receiver
 * 8x oversampling, start-bit validation, mid-bit sampling, stop-bit check
 */
`default_nettype none

module uart_receive
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic uart_rx,
	output uart_pkg::rx_entry_t rx_entry,
	output logic rx_valid
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;

	// Two-flop synchronizer on the async line
	logic rx_meta;
	logic rx_sync;

	// Sample tick divider
	logic [$clog2(uart_pkg::CLKS_PER_SAMPLE)-1:0] div_cnt;
	logic sample_tick;

	logic [$clog2(uart_pkg::SAMPLES_PER_BIT)-1:0] sample_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;

	logic mid_start;
	logic bit_point;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// Line idles high
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			div_cnt <= '0;
		else if (sample_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign sample_tick = int'(div_cnt) == uart_pkg::CLKS_PER_SAMPLE - 1;

	// Half a bit after the falling edge
	assign mid_start = sample_tick && state == RX_START
		&& int'(sample_cnt) == uart_pkg::SAMPLES_PER_BIT / 2 - 1;
	// Middle of a data or stop bit, one full bit after the previous sample
	assign bit_point = sample_tick && (state == RX_DATA || state == RX_STOP)
		&& int'(sample_cnt) == uart_pkg::SAMPLES_PER_BIT - 1;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= RX_IDLE;
			sample_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			// Single-cycle pulse
			rx_valid <= 1'b0;
			if (sample_tick)
			begin
				case (state)
					RX_IDLE:
					begin
						// Falling edge seen on a tick
						if (!rx_sync)
						begin
							state <= RX_START;
							sample_cnt <= '0;
						end
					end

					RX_START:
					begin
						if (mid_start)
						begin
							// Glitch if the line is already back high
							state <= rx_sync ? RX_IDLE : RX_DATA;
							sample_cnt <= '0;
							bit_cnt <= '0;
						end
						else
							sample_cnt <= sample_cnt + 1'b1;
					end

					RX_DATA:
					begin
						if (bit_point)
						begin
							sample_cnt <= '0;
							if (int'(bit_cnt) == $bits(shift_reg) - 1)
								state <= RX_STOP;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							sample_cnt <= sample_cnt + 1'b1;
					end

					RX_STOP:
					begin
						if (bit_point)
						begin
							// Deliver even with a bad stop bit
							state <= RX_IDLE;
							rx_valid <= 1'b1;
						end
						else
							sample_cnt <= sample_cnt + 1'b1;
					end

					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Character assembly, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (bit_point && state == RX_DATA)
			shift_reg <= {rx_sync, shift_reg[7:1]};
		if (bit_point && state == RX_STOP)
		begin
			rx_entry.data <= shift_reg;
			rx_entry.frame_error <= !rx_sync;
		end
	end

	// A full frame separates any two deliveries
	valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		rx_valid |=> !rx_valid)
		else $error("uart_receive: rx_valid held two cycles");

endmodule

`default_nettype wire

// ==== design/uart_transmit.sv ====
/*
 * Serial transmitter
 * Sends one 8N1 frame per accepted character, LSB first
 */
`default_nettype none

module uart_transmit
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic tx_start,
	input wire logic [7:0] tx_char,
	output logic tx_ready,
	output logic uart_tx
);

	logic busy;
	// Clocks within the current bit
	logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] period_cnt;
	// Bits of the frame already sent
	logic [$clog2(uart_pkg::FRAME_BITS)-1:0] bit_cnt;
	// Frame shifter, bit 0 drives the line
	logic [uart_pkg::FRAME_BITS-1:0] shift_reg;

	logic bit_end;

	assign tx_ready = !busy;
	// Idle shifter holds all ones so the line rests high
	assign uart_tx = shift_reg[0];

	assign bit_end = int'(period_cnt) == uart_pkg::CLKS_PER_BIT - 1;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			period_cnt <= '0;
			bit_cnt <= '0;
			shift_reg <= '1;
		end
		else if (tx_start)
		begin
			// Stop bit, data, start bit
			busy <= 1'b1;
			period_cnt <= '0;
			bit_cnt <= '0;
			shift_reg <= {1'b1, tx_char, 1'b0};
		end
		else if (busy)
		begin
			if (bit_end)
			begin
				period_cnt <= '0;
				// Shift in ones behind the frame
				shift_reg <= {1'b1, shift_reg[uart_pkg::FRAME_BITS-1:1]};
				if (int'(bit_cnt) == uart_pkg::FRAME_BITS - 1)
					busy <= 1'b0;
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
			else
				period_cnt <= period_cnt + 1'b1;
		end
	end

	// Top level must hold off writes until the frame is out
	start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		tx_start |-> !busy)
		else $error("uart_transmit: start while busy");

endmodule

`default_nettype wire

// ==== design/sync_fifo.sv ====
/*
 * Receive FIFO
 * Circular buffer of receive entries, head visible without read latency
 */
`default_nettype none

module sync_fifo
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic enqueue,
	input wire uart_pkg::rx_entry_t wr_entry,
	input wire logic dequeue,
	output uart_pkg::rx_entry_t rd_entry,
	output logic full,
	output logic empty
);

	// Entry storage
	uart_pkg::rx_entry_t mem [uart_pkg::RX_FIFO_DEPTH];

	logic [$clog2(uart_pkg::RX_FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(uart_pkg::RX_FIFO_DEPTH)-1:0] rd_ptr;
	// One extra bit so a full buffer is representable
	logic [$clog2(uart_pkg::RX_FIFO_DEPTH):0] count;

	assign full = int'(count) == uart_pkg::RX_FIFO_DEPTH;
	assign empty = count == '0;

	// Head entry straight out of the array
	assign rd_entry = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (enqueue)
			mem[wr_ptr] <= wr_entry;
	end

	// Pointers and occupancy
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue)
			begin
				// Wrap at the last slot
				if (int'(wr_ptr) == uart_pkg::RX_FIFO_DEPTH - 1)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end

			if (dequeue)
			begin
				if (int'(rd_ptr) == uart_pkg::RX_FIFO_DEPTH - 1)
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end

			// Simultaneous push and pop leaves the count alone
			case ({enqueue, dequeue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Occupancy bound across any push/pop history
	count_bound: assert property (@(posedge clk) disable iff (!arst_n)
		int'(count) <= uart_pkg::RX_FIFO_DEPTH)
		else $error("sync_fifo: occupancy %0d above depth", count);

endmodule

`default_nettype wire

// ==== design/uart_pkg.sv ====
/*
 * Serial port shared definitions
 * Bit timing, register map, receive entry and read word layouts
 */
`default_nettype none

package uart_pkg;

	// Receiver oversampling, one sample tick every CLKS_PER_SAMPLE clocks
	localparam int CLKS_PER_SAMPLE = 2;
	localparam int SAMPLES_PER_BIT = 8;

	// One serial bit period in clocks
	localparam int CLKS_PER_BIT = CLKS_PER_SAMPLE * SAMPLES_PER_BIT;

	// Start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;

	// Receive FIFO entries
	localparam int RX_FIFO_DEPTH = 8;

	// Register map
	localparam logic [31:0] STATUS_ADDR = 32'h0000_0000;
	localparam logic [31:0] RX_ADDR = 32'h0000_0004;
	localparam logic [31:0] TX_ADDR = 32'h0000_0008;

	// Received character with its error flag, bit 8 is frame_error
	typedef struct packed {
		logic frame_error;
		logic [7:0] data;
	} rx_entry_t;

	// Status register, tx_ready in bit 0
	typedef struct packed {
		logic [28:0] reserved;
		logic rx_overrun;
		logic rx_available;
		logic tx_ready;
	} status_t;

	// Receive data register, entry in the low bits
	typedef struct packed {
		logic [31 - $bits(rx_entry_t):0] reserved;
		rx_entry_t entry;
	} rx_view_t;

	// Read word, decoded by address
	typedef union packed {
		status_t status;
		rx_view_t rx;
	} io_word_u;

endpackage

`default_nettype wire
